/* hdl/eeprom_pkg.sv */
package eeprom_pkg;

    localparam int ADDR_W = 11;   // 2 Kbyte array
    localparam int DATA_W = 8;

    // high nibble of the control byte
    localparam logic [3:0] DEV_TYPE = 4'b1010;

    localparam int FIFO_DEPTH = 4;

    // CLK cycles per SCL bit, one per quarter phase
    localparam int BIT_CYCLES = 4;

    // one-hot engine state, bit positions
    localparam int ST_W     = 10;
    localparam int S_IDLE   = 0;
    localparam int S_START  = 1;
    localparam int S_CTRL   = 2;  // control byte, write bit
    localparam int S_ADDR   = 3;
    localparam int S_DATA   = 4;
    localparam int S_RSTART = 5;  // repeated start
    localparam int S_CTRLR  = 6;  // control byte, read bit
    localparam int S_READ   = 7;
    localparam int S_MNACK  = 8;
    localparam int S_STOP   = 9;

endpackage

/* hdl/eeprom_cmd_if.sv */
interface eeprom_cmd_if;

    logic                          push;
    logic                          pop;
    logic                          is_read;
    logic [eeprom_pkg::ADDR_W-1:0] addr;
    logic [eeprom_pkg::DATA_W-1:0] wdata;
    logic                          full;
    logic                          empty;

    // request side, feeds the queue
    modport producer (output push, is_read, addr, wdata, input full);

    // bus engine side, takes the head
    modport consumer (output pop, input is_read, addr, wdata, empty);

    // queue ends, mirror images of the two above
    modport fifo_wr (input push, is_read, addr, wdata, output full);
    modport fifo_rd (input pop, output is_read, addr, wdata, empty);

endinterface

/* hdl/eeprom_req_capture.sv */
module eeprom_req_capture (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    output logic                          busy,
    eeprom_cmd_if.producer                cmd
);

    logic                          pend_valid;
    logic                          pend_is_read;
    logic [eeprom_pkg::ADDR_W-1:0] pend_addr;
    logic [eeprom_pkg::DATA_W-1:0] pend_wdata;
    logic                          take;

    // slot stuck behind a full queue
    assign busy = pend_valid & cmd.full;
    assign take = (wr | rd) & ~busy;

    assign cmd.push    = pend_valid & ~cmd.full;
    assign cmd.is_read = pend_is_read;
    assign cmd.addr    = pend_addr;
    assign cmd.wdata   = pend_wdata;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pend_valid <= 1'b0;
        else if (take)
            pend_valid <= 1'b1;   // refill even while the old one is pushed
        else if (cmd.push)
            pend_valid <= 1'b0;
    end

    always_ff @(posedge CLK)
    begin
        if (take)
        begin
            pend_is_read <= ~wr;  // wr wins
            pend_addr    <= addr;
            pend_wdata   <= wdata;
        end
    end

endmodule

/* hdl/eeprom_cmd_fifo.sv */
module eeprom_cmd_fifo (
    input  logic          CLK,
    input  logic          RESET,
    eeprom_cmd_if.fifo_wr wr_side,
    eeprom_cmd_if.fifo_rd rd_side
);

    logic [eeprom_pkg::ADDR_W+eeprom_pkg::DATA_W:0] mem [eeprom_pkg::FIFO_DEPTH];
    logic [eeprom_pkg::ADDR_W+eeprom_pkg::DATA_W:0] head;

    logic [$clog2(eeprom_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(eeprom_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(eeprom_pkg::FIFO_DEPTH):0]   count;
    logic [$clog2(eeprom_pkg::FIFO_DEPTH):0]   count_nxt;
    logic                                      do_push;
    logic                                      do_pop;

    assign do_push = wr_side.push & ~wr_side.full;
    assign do_pop  = rd_side.pop & ~rd_side.empty;

    always_comb
    begin
        count_nxt = count;
        if (do_push && !do_pop)
            count_nxt = count + 1'b1;
        else if (do_pop && !do_push)
            count_nxt = count - 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= {wr_side.is_read, wr_side.addr, wr_side.wdata};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            wr_side.full  <= 1'b0;
            rd_side.empty <= 1'b1;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count         <= count_nxt;
            wr_side.full  <= (count_nxt == eeprom_pkg::FIFO_DEPTH);
            rd_side.empty <= (count_nxt == 0);
        end
    end

    // head is valid whenever empty is low
    assign head            = mem[rd_ptr];
    assign rd_side.is_read = head[eeprom_pkg::ADDR_W+eeprom_pkg::DATA_W];
    assign rd_side.addr    = head[eeprom_pkg::ADDR_W+eeprom_pkg::DATA_W-1:eeprom_pkg::DATA_W];
    assign rd_side.wdata   = head[eeprom_pkg::DATA_W-1:0];

endmodule

/* hdl/eeprom_serial_engine.sv */
module eeprom_serial_engine (
    input  logic                          CLK,
    input  logic                          RESET,
    eeprom_cmd_if.consumer                cmd,
    input  logic                          sda_in,
    output logic                          scl,
    output logic                          sda_drive_low,
    output logic                          ack,
    output logic                          nack,
    output logic [eeprom_pkg::DATA_W-1:0] rdata
);

    logic [eeprom_pkg::ST_W-1:0]   state;
    logic [1:0]                    qtr;
    logic [3:0]                    bit_cnt;
    logic [eeprom_pkg::DATA_W-1:0] shreg;
    logic                          is_rd_q;
    logic [eeprom_pkg::ADDR_W-1:0] addr_q;
    logic [eeprom_pkg::DATA_W-1:0] wdata_q;
    logic                          nack_seen;
    logic                          qtr_last;
    logic                          byte_out;
    logic                          ack_slot;

    function automatic logic [eeprom_pkg::ST_W-1:0] onehot(input int idx);
        onehot      = '0;
        onehot[idx] = 1'b1;
    endfunction

    assign qtr_last = (qtr == 2'(eeprom_pkg::BIT_CYCLES - 1));

    // bytes the master shifts out, each followed by a device ack bit
    assign byte_out = state[eeprom_pkg::S_CTRL] | state[eeprom_pkg::S_ADDR] |
                      state[eeprom_pkg::S_DATA] | state[eeprom_pkg::S_CTRLR];
    assign ack_slot = byte_out && (bit_cnt == 4'd8);

    assign cmd.pop = state[eeprom_pkg::S_IDLE] & ~cmd.empty;

    // pin decode, SCL high in quarters 1 and 2 of a data bit
    always_comb
    begin
        scl           = 1'b1;
        sda_drive_low = 1'b0;
        if (state[eeprom_pkg::S_START])
        begin
            scl           = (qtr != 2'd3);
            sda_drive_low = qtr[1];        // falls in quarter 2, SCL still high
        end
        else if (state[eeprom_pkg::S_RSTART])
        begin
            scl           = qtr[0] ^ qtr[1];
            sda_drive_low = qtr[1];
        end
        else if (state[eeprom_pkg::S_STOP])
        begin
            scl           = (qtr != 2'd0);
            sda_drive_low = ~qtr[1];       // released in quarter 2
        end
        else if (!state[eeprom_pkg::S_IDLE])
        begin
            scl           = qtr[0] ^ qtr[1];
            sda_drive_low = byte_out && !ack_slot && !shreg[7];
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= onehot(eeprom_pkg::S_IDLE);
            qtr       <= 2'd0;
            bit_cnt   <= 4'd0;
            nack_seen <= 1'b0;
            ack       <= 1'b0;
            nack      <= 1'b0;
            rdata     <= '0;
        end
        else if (state[eeprom_pkg::S_IDLE])
        begin
            ack       <= 1'b0;
            nack      <= 1'b0;
            qtr       <= 2'd0;
            bit_cnt   <= 4'd0;
            nack_seen <= 1'b0;
            if (!cmd.empty)
                state <= onehot(eeprom_pkg::S_START);
        end
        else
        begin
            ack  <= 1'b0;
            nack <= 1'b0;
            qtr  <= qtr + 2'd1;

            if (qtr == 2'd2)  // sample point, end of the second high quarter
            begin
                if (ack_slot && sda_in)
                    nack_seen <= 1'b1;
                if (state[eeprom_pkg::S_READ])
                    shreg <= {shreg[eeprom_pkg::DATA_W-2:0], sda_in};
            end

            if (qtr_last)
            begin
                bit_cnt <= bit_cnt + 4'd1;
                if (byte_out)
                    shreg <= {shreg[eeprom_pkg::DATA_W-2:0], 1'b0};

                case (1'b1)
                    state[eeprom_pkg::S_START]:
                    begin
                        shreg   <= {eeprom_pkg::DEV_TYPE,
                                    addr_q[eeprom_pkg::ADDR_W-1:eeprom_pkg::DATA_W], 1'b0};
                        bit_cnt <= 4'd0;
                        state   <= onehot(eeprom_pkg::S_CTRL);
                    end
                    state[eeprom_pkg::S_CTRL]:
                        if (ack_slot)
                        begin
                            shreg   <= addr_q[eeprom_pkg::DATA_W-1:0];
                            bit_cnt <= 4'd0;
                            state   <= onehot(nack_seen ? eeprom_pkg::S_STOP
                                                        : eeprom_pkg::S_ADDR);
                        end
                    state[eeprom_pkg::S_ADDR]:
                        if (ack_slot)
                        begin
                            shreg   <= wdata_q;
                            bit_cnt <= 4'd0;
                            if (nack_seen)
                                state <= onehot(eeprom_pkg::S_STOP);
                            else if (is_rd_q)
                                state <= onehot(eeprom_pkg::S_RSTART);
                            else
                                state <= onehot(eeprom_pkg::S_DATA);
                        end
                    state[eeprom_pkg::S_DATA]:
                        if (ack_slot)
                            state <= onehot(eeprom_pkg::S_STOP);
                    state[eeprom_pkg::S_RSTART]:
                    begin
                        shreg   <= {eeprom_pkg::DEV_TYPE,
                                    addr_q[eeprom_pkg::ADDR_W-1:eeprom_pkg::DATA_W], 1'b1};
                        bit_cnt <= 4'd0;
                        state   <= onehot(eeprom_pkg::S_CTRLR);
                    end
                    state[eeprom_pkg::S_CTRLR]:
                        if (ack_slot)
                        begin
                            bit_cnt <= 4'd0;
                            state   <= onehot(nack_seen ? eeprom_pkg::S_STOP
                                                        : eeprom_pkg::S_READ);
                        end
                    state[eeprom_pkg::S_READ]:
                        if (bit_cnt == 4'd7)
                            state <= onehot(eeprom_pkg::S_MNACK);
                    state[eeprom_pkg::S_MNACK]:
                        state <= onehot(eeprom_pkg::S_STOP);
                    state[eeprom_pkg::S_STOP]:
                    begin
                        ack  <= ~nack_seen;
                        nack <= nack_seen;
                        if (is_rd_q && !nack_seen)
                            rdata <= shreg;
                        state <= onehot(eeprom_pkg::S_IDLE);
                    end
                    default:
                        state <= onehot(eeprom_pkg::S_IDLE);
                endcase
            end
        end
    end

    // command fields, taken with the pop
    always_ff @(posedge CLK)
    begin
        if (cmd.pop)
        begin
            is_rd_q <= cmd.is_read;
            addr_q  <= cmd.addr;
            wdata_q <= cmd.wdata;
        end
    end

endmodule

/* hdl/eeprom_ctrl_top.sv */
module eeprom_ctrl_top (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    input  logic                          sda_in,
    output logic                          busy,
    output logic                          ack,
    output logic                          nack,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output logic                          scl,
    output logic                          sda_drive_low
);

    eeprom_cmd_if cmd_in ();    // capture to queue
    eeprom_cmd_if cmd_out ();   // queue to bus engine

    eeprom_req_capture u_req_capture (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .busy  (busy),
        .cmd   (cmd_in)
    );

    eeprom_cmd_fifo u_cmd_fifo (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr_side (cmd_in),
        .rd_side (cmd_out)
    );

    eeprom_serial_engine u_serial_engine (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd           (cmd_out),
        .sda_in        (sda_in),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .ack           (ack),
        .nack          (nack),
        .rdata         (rdata)
    );

endmodule

/* sim/eeprom_slave_model.sv */
module eeprom_slave_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_drive_low
);

    localparam int BUSY_CYCLES = 400;  // write cycle time, in CLK cycles

    localparam int PH_IDLE = 0;
    localparam int PH_CTRL = 1;
    localparam int PH_ADDR = 2;
    localparam int PH_DATA = 3;
    localparam int PH_TX   = 4;  // sending read data

    logic [eeprom_pkg::DATA_W-1:0] mem [0:2**eeprom_pkg::ADDR_W-1];
    logic [eeprom_pkg::ADDR_W-1:0] addr_q;
    logic [7:0]                    shift;
    logic [7:0]                    tx_byte;
    logic                          scl_q;
    logic                          sda_q;
    logic                          in_ack;
    int                            phase;
    int                            next_phase;
    int                            bit_cnt;
    int                            cyc;
    int                            busy_set;
    int                            busy_end;
    int                            cleared_at;

    initial
    begin
        for (int i = 0; i < 2**eeprom_pkg::ADDR_W; i++)
            mem[i] = '0;
        cleared_at = 0;
    end

    // ends the current write cycle early
    task clear_busy();
        cleared_at = cyc + 1;
    endtask

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            sda_drive_low <= 1'b0;
            scl_q    = 1'b1;
            sda_q    = 1'b1;
            phase    = PH_IDLE;
            bit_cnt  = 0;
            in_ack   = 1'b0;
            cyc      = 0;
            busy_set = -1;
            busy_end = 0;
        end
        else
        begin
            cyc = cyc + 1;
            if (scl && scl_q && sda_q && !sda)          // start or repeated start
            begin
                phase   = PH_CTRL;
                bit_cnt = 0;
                in_ack  = 1'b0;
                sda_drive_low <= 1'b0;
            end
            else if (scl && scl_q && !sda_q && sda)     // stop
            begin
                phase  = PH_IDLE;
                in_ack = 1'b0;
                sda_drive_low <= 1'b0;
            end
            else if (scl && !scl_q)
            begin
                if (phase == PH_TX)
                    bit_cnt = bit_cnt + 1;
                else if (phase != PH_IDLE && !in_ack && bit_cnt < 8)
                begin
                    shift   = {shift[6:0], sda};
                    bit_cnt = bit_cnt + 1;
                end
            end
            else if (!scl && scl_q)
            begin
                if (phase == PH_TX)
                begin
                    if (bit_cnt < 8)
                    begin
                        sda_drive_low <= ~tx_byte[7];
                        tx_byte = {tx_byte[6:0], 1'b0};
                    end
                    else
                        sda_drive_low <= 1'b0;  // master ack bit
                end
                else if (in_ack)
                begin
                    in_ack  = 1'b0;
                    bit_cnt = 0;
                    phase   = next_phase;
                    sda_drive_low <= 1'b0;
                    if (phase == PH_TX)
                    begin
                        tx_byte = mem[addr_q];
                        sda_drive_low <= ~tx_byte[7];
                        tx_byte = {tx_byte[6:0], 1'b0};
                    end
                end
                else if (phase != PH_IDLE && bit_cnt == 8)
                begin
                    in_ack     = 1'b1;
                    next_phase = PH_IDLE;
                    case (phase)
                        PH_CTRL:
                            if (shift[7:4] == eeprom_pkg::DEV_TYPE &&
                                !(cyc < busy_end && busy_set >= cleared_at))
                            begin
                                addr_q[10:8] = shift[3:1];
                                next_phase   = shift[0] ? PH_TX : PH_ADDR;
                                sda_drive_low <= 1'b1;
                            end
                        PH_ADDR:
                        begin
                            addr_q[7:0] = shift;
                            next_phase  = PH_DATA;
                            sda_drive_low <= 1'b1;
                        end
                        default:
                        begin
                            mem[addr_q] = shift;
                            busy_set    = cyc;
                            busy_end    = cyc + BUSY_CYCLES;
                            sda_drive_low <= 1'b1;
                        end
                    endcase
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

/* sim/eeprom_ctrl_assert.sv */
module eeprom_ctrl_assert (
    input logic CLK,
    input logic RESET,
    input logic wr,
    input logic rd,
    input logic busy,
    input logic ack,
    input logic nack,
    input logic scl,
    input logic sda_drive_low,
    input logic sda_in
);

    ack_nack_exclusive: assert property (@(posedge CLK) disable iff (RESET)
        !(ack && nack))
        else $error("ack and nack high together");

    // only the master may move SDA under a high SCL, as start or stop
    sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_in != $past(sda_in)))
            |-> (sda_drive_low != $past(sda_drive_low)))
        else $error("SDA changed during SCL high without a start or stop");

    busy_after_strobe: assert property (@(posedge CLK) disable iff (RESET)
        $rose(busy) |-> $past(wr || rd))
        else $error("busy rose without a request strobe");

    scl_low_width: assert property (@(posedge CLK) disable iff (RESET)
        $fell(scl) |-> ##(eeprom_pkg::BIT_CYCLES / 2) scl)
        else $error("SCL low phase too long");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_assert u_assert (.*);

/* sim/eeprom_ctrl_tb.sv */
module eeprom_ctrl_tb;

    localparam int TIMEOUT      = 3000;  // CLK cycles per completion
    localparam int QUIET_CYCLES = 300;

    logic                          CLK;
    logic                          RESET;
    logic                          wr;
    logic                          rd;
    logic [eeprom_pkg::ADDR_W-1:0] addr;
    logic [eeprom_pkg::DATA_W-1:0] wdata;
    logic                          sda_in;
    logic                          busy;
    logic                          ack;
    logic                          nack;
    logic [eeprom_pkg::DATA_W-1:0] rdata;
    logic                          scl;
    logic                          sda_drive_low;
    logic                          slave_drive_low;

    logic [eeprom_pkg::DATA_W-1:0] shadow [0:2**eeprom_pkg::ADDR_W-1];

    assign sda_in = ~(sda_drive_low | slave_drive_low);  // open drain wire

    eeprom_ctrl_top u_dut (
        .CLK           (CLK),
        .RESET         (RESET),
        .wr            (wr),
        .rd            (rd),
        .addr          (addr),
        .wdata         (wdata),
        .sda_in        (sda_in),
        .busy          (busy),
        .ack           (ack),
        .nack          (nack),
        .rdata         (rdata),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

    eeprom_slave_model u_slave (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda           (sda_in),
        .sda_drive_low (slave_drive_low)
    );

    initial
        CLK = 1'b0;

    always #5 CLK = ~CLK;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected)
            abort_run($sformatf("Mismatch in %s: expected %0h, actual %0h",
                                name, expected, actual));
    endtask

    // the DUT takes the strobe at the next edge only if busy is low at the negedge
    task automatic strobe(input logic is_rd, input logic [10:0] a, input logic [7:0] d,
                          output logic accepted);
        @(posedge CLK);
        wr    <= ~is_rd;
        rd    <= is_rd;
        addr  <= a;
        wdata <= d;
        @(negedge CLK);
        accepted = ~busy;
    endtask

    task automatic release_strobes();
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic await_done(input string name, input logic clear_window,
                              output logic got_ack, output logic got_nack,
                              output logic [7:0] data);
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done)
        begin
            @(negedge CLK);
            if (ack || nack)
            begin
                done     = 1'b1;
                got_ack  = ack;
                got_nack = nack;
                data     = rdata;
            end
            else
            begin
                n = n + 1;
                if (n > TIMEOUT)
                    abort_run($sformatf("%s: transaction never completed", name));
            end
        end
        if (clear_window)
            u_slave.clear_busy();
    endtask

    task automatic watch_quiet(input string name);
        for (int n = 0; n < QUIET_CYCLES; n++)
        begin
            @(negedge CLK);
            if (ack || nack)
                abort_run($sformatf("%s: completion pulse with no request left", name));
        end
    endtask

    task automatic write_byte(input string name, input logic [10:0] a, input logic [7:0] d);
        logic       accepted;
        logic       got_ack;
        logic       got_nack;
        logic [7:0] data;
        strobe(1'b0, a, d, accepted);
        release_strobes();
        check(name, 32'd1, 32'(accepted));
        shadow[a] = d;
        await_done(name, 1'b1, got_ack, got_nack, data);
        check(name, 32'd1, 32'(got_ack));
        check(name, 32'd0, 32'(got_nack));
    endtask

    task automatic read_byte(input string name, input logic [10:0] a);
        logic       accepted;
        logic       got_ack;
        logic       got_nack;
        logic [7:0] data;
        strobe(1'b1, a, 8'h00, accepted);
        release_strobes();
        check(name, 32'd1, 32'(accepted));
        await_done(name, 1'b1, got_ack, got_nack, data);
        check(name, 32'd1, 32'(got_ack));
        check(name, 32'd0, 32'(got_nack));
        check(name, 32'(shadow[a]), 32'(data));
    endtask

    task automatic reset_values();
        @(negedge CLK);
        check("reset_state", 32'd0, 32'(busy));
        check("reset_state", 32'd0, 32'(ack));
        check("reset_state", 32'd0, 32'(nack));
        check("reset_state", 32'd1, 32'(scl));
        check("reset_state", 32'd0, 32'(sda_drive_low));
        check("reset_state", 32'd0, 32'(rdata));
    endtask

    task automatic write_read_back();
        write_byte("write_read", 11'h2a5, 8'h5c);
        read_byte("write_read", 11'h2a5);
    endtask

    // same two offsets in every block, all written before any read
    task automatic block_decoding();
        logic [31:0] r;
        logic [7:0]  lo [2];
        logic [10:0] a;
        r     = $urandom;
        lo[0] = r[7:0];
        lo[1] = ~r[7:0];
        for (int blk = 0; blk < 8; blk++)
            for (int j = 0; j < 2; j++)
            begin
                a = {3'(blk), lo[j]};
                write_byte("blocks", a, {r[15:12], 3'(blk), 1'(j)});
            end
        for (int blk = 0; blk < 8; blk++)
            for (int j = 0; j < 2; j++)
                read_byte("blocks", {3'(blk), lo[j]});
    endtask

    task automatic queued_requests();
        logic [31:0] r;
        logic [10:0] qa [3];
        logic [7:0]  qd [3];
        logic        accepted;
        logic        got_ack;
        logic        got_nack;
        logic [7:0]  data;
        r = $urandom;
        for (int i = 0; i < 3; i++)
        begin
            qa[i] = {r[10:2], 2'(i)};
            qd[i] = {r[20:16], 3'(i)};  // distinct per request
        end
        for (int i = 0; i < 6; i++)
        begin
            strobe(i >= 3, qa[i % 3], qd[i % 3], accepted);
            check("queued", 32'd1, 32'(accepted));
            if (i < 3)
                shadow[qa[i]] = qd[i];
        end
        release_strobes();
        for (int i = 0; i < 6; i++)
        begin
            await_done("queued", 1'b1, got_ack, got_nack, data);
            check("queued", 32'd1, 32'(got_ack));
            check("queued", 32'd0, 32'(got_nack));
            if (i >= 3)
                check("queued", 32'(qd[i - 3]), 32'(data));
        end
        watch_quiet("queued");
    endtask

    task automatic back_pressure();
        logic [31:0] r;
        logic        accepted;
        logic        got_ack;
        logic        got_nack;
        logic [7:0]  data;
        logic        stop;
        int          count;
        count = 0;
        stop  = 1'b0;
        while (!stop)
        begin
            r = $urandom;
            strobe(1'b0, r[10:0], r[23:16], accepted);
            if (accepted)
            begin
                if (count >= 8)
                    abort_run("back_pressure: busy never rose");
                shadow[r[10:0]] = r[23:16];
                count = count + 1;
            end
            else
                stop = 1'b1;
        end
        release_strobes();
        check("back_pressure", 32'd6, 32'(count));
        for (int i = 0; i < count; i++)
        begin
            await_done("back_pressure", 1'b1, got_ack, got_nack, data);
            check("back_pressure", 32'd1, 32'(got_ack));
            check("back_pressure", 32'd0, 32'(got_nack));
        end
        watch_quiet("back_pressure");
    endtask

    task automatic device_no_ack();
        logic       accepted;
        logic       got_ack;
        logic       got_nack;
        logic [7:0] data;
        strobe(1'b0, 11'h0f3, 8'h96, accepted);
        check("no_ack", 32'd1, 32'(accepted));
        strobe(1'b1, 11'h0f3, 8'h00, accepted);   // lands in the write cycle
        check("no_ack", 32'd1, 32'(accepted));
        release_strobes();
        shadow[11'h0f3] = 8'h96;
        await_done("no_ack", 1'b0, got_ack, got_nack, data);
        check("no_ack", 32'd1, 32'(got_ack));
        await_done("no_ack", 1'b0, got_ack, got_nack, data);
        check("no_ack", 32'd0, 32'(got_ack));
        check("no_ack", 32'd1, 32'(got_nack));
        u_slave.clear_busy();
        read_byte("no_ack", 11'h0f3);
    endtask

    initial
    begin
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = '0;
        for (int i = 0; i < 2**eeprom_pkg::ADDR_W; i++)
            shadow[i] = '0;
        void'($urandom(32'h29b9_3a80));
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;

        reset_values();
        write_read_back();
        block_decoding();
        queued_requests();
        back_pressure();
        device_no_ack();

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* vlog.f */
hdl/eeprom_pkg.sv
hdl/eeprom_cmd_if.sv
hdl/eeprom_req_capture.sv
hdl/eeprom_cmd_fifo.sv
hdl/eeprom_serial_engine.sv
hdl/eeprom_ctrl_top.sv
sim/eeprom_slave_model.sv
sim/eeprom_ctrl_assert.sv
sim/eeprom_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile with Verilator and run the EEPROM controller testbench.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f \
        --top-module eeprom_ctrl_tb -o eeprom_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/eeprom_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
